// File: cnn_sched.f
hw/cnn_sched_pkg.sv
hw/layer_config.sv
hw/loop_sequencer.sv
hw/tile_fetch.sv
hw/buf_arbiter.sv
hw/tile_buffer.sv
hw/cnn_sched_top.sv
tb/cnn_sched_tb.sv

// File: hw/buf_arbiter.sv
`timescale 1ns/1ps
// Tile buffer arbiter
// Host writes always take the cycle. Otherwise the activation and
// weight fetchers share the port round robin. The owner of each read
// is registered so the returned word is steered back to its fetcher.
module buf_arbiter (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             host_wr_en,
    input  cnn_sched_pkg::mem_wr_t           host_wr,
    input  logic                             act_req,
    input  logic [cnn_sched_pkg::ADDR_W-1:0] act_addr,
    input  logic                             wgt_req,
    input  logic [cnn_sched_pkg::ADDR_W-1:0] wgt_addr,
    output logic                             act_gnt,
    output logic                             wgt_gnt,
    output logic                             act_rvalid,
    output logic                             wgt_rvalid,
    output logic                             mem_en,
    output logic                             mem_we,
    output logic [cnn_sched_pkg::ADDR_W-1:0] mem_addr,
    output logic [cnn_sched_pkg::DATA_W-1:0] mem_wdata
);

    cnn_sched_pkg::arb_src_e cur_src;
    cnn_sched_pkg::arb_src_e rd_src;
    logic                    last_wgt;

    // ============================================================
    // Owner select
    // ============================================================
    always_comb begin
        cur_src = cnn_sched_pkg::SRC_NONE;
        if (host_wr_en) begin
            cur_src = cnn_sched_pkg::SRC_HOST;
        end else if (act_req && wgt_req) begin
            // Alternate on contention
            cur_src = last_wgt ? cnn_sched_pkg::SRC_ACT : cnn_sched_pkg::SRC_WGT;
        end else if (act_req) begin
            cur_src = cnn_sched_pkg::SRC_ACT;
        end else if (wgt_req) begin
            cur_src = cnn_sched_pkg::SRC_WGT;
        end
    end

    assign act_gnt = (cur_src == cnn_sched_pkg::SRC_ACT);
    assign wgt_gnt = (cur_src == cnn_sched_pkg::SRC_WGT);

    // Buffer port drive
    assign mem_en    = (cur_src != cnn_sched_pkg::SRC_NONE);
    assign mem_we    = (cur_src == cnn_sched_pkg::SRC_HOST);
    assign mem_wdata = host_wr.data;
    always_comb begin
        case (cur_src)
            cnn_sched_pkg::SRC_HOST: mem_addr = host_wr.addr;
            cnn_sched_pkg::SRC_WGT:  mem_addr = wgt_addr;
            default:                 mem_addr = act_addr;
        endcase
    end

    // ============================================================
    // Read owner and round robin state
    // ============================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_src   <= cnn_sched_pkg::SRC_NONE;
            last_wgt <= 1'b0;
        end else begin
            // Writes return nothing
            rd_src <= (cur_src == cnn_sched_pkg::SRC_HOST) ? cnn_sched_pkg::SRC_NONE : cur_src;
            if (act_gnt) last_wgt <= 1'b0;
            if (wgt_gnt) last_wgt <= 1'b1;
        end
    end

    assign act_rvalid = (rd_src == cnn_sched_pkg::SRC_ACT);
    assign wgt_rvalid = (rd_src == cnn_sched_pkg::SRC_WGT);

endmodule

// File: hw/cnn_sched_pkg.sv
// Layer scheduler shared definitions
// Buffer geometry, configuration queue sizing, the layer entry
// and fetch command formats, and the sequencer and arbiter enums.
package cnn_sched_pkg;

    // ============================================================
    // Sizes
    // ============================================================
    localparam int DATA_W    = 16;
    localparam int ADDR_W    = 8;
    localparam int CFG_DEPTH = 4;
    localparam int CFG_PTR_W = 2;

    // ============================================================
    // Packed formats
    // ============================================================
    // One layer entry, counts stored minus one
    typedef struct packed {
        logic [3:0] num_pat;
        logic [2:0] num_ftr_grp;
        logic [3:0] len_row;
        logic [7:0] act_base;
        logic [7:0] wgt_base;
    } layer_cfg_t;

    // Tile request to a fetcher
    typedef struct packed {
        logic [7:0] base;
        logic [3:0] len;
    } fetch_cmd_t;

    // Host write into the tile buffer
    typedef struct packed {
        logic [7:0]  addr;
        logic [15:0] data;
    } mem_wr_t;

    // ============================================================
    // Enums
    // ============================================================
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_WAIT,
        SEQ_STEP
    } seq_state_e;

    // Buffer owner in a given cycle
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_HOST,
        SRC_ACT,
        SRC_WGT
    } arb_src_e;

endpackage

// File: hw/cnn_sched_top.sv
`timescale 1ns/1ps
// Convolution layer scheduler top
// Configuration queue, loop sequencer, activation and weight tile
// fetchers, buffer arbiter and the shared single-port tile buffer.
module cnn_sched_top (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             cfg_val,
    input  cnn_sched_pkg::layer_cfg_t        cfg,
    output logic                             cfg_full,
    input  logic                             mem_wr_en,
    input  cnn_sched_pkg::mem_wr_t           mem_wr,
    output logic                             act_val,
    output logic [cnn_sched_pkg::DATA_W-1:0] act_data,
    output logic                             wgt_val,
    output logic [cnn_sched_pkg::DATA_W-1:0] wgt_data,
    output logic                             layer_done,
    output logic                             busy
);

    // ============================================================
    // Interconnect
    // ============================================================
    logic                             cfg_valid;
    cnn_sched_pkg::layer_cfg_t        head;
    logic                             act_start;
    logic                             wgt_start;
    cnn_sched_pkg::fetch_cmd_t        act_cmd;
    cnn_sched_pkg::fetch_cmd_t        wgt_cmd;
    logic                             act_done;
    logic                             wgt_done;
    logic                             act_req;
    logic                             wgt_req;
    logic [cnn_sched_pkg::ADDR_W-1:0] act_addr;
    logic [cnn_sched_pkg::ADDR_W-1:0] wgt_addr;
    logic                             act_gnt;
    logic                             wgt_gnt;
    logic                             act_rvalid;
    logic                             wgt_rvalid;
    logic                             mem_en;
    logic                             mem_we;
    logic [cnn_sched_pkg::ADDR_W-1:0] mem_addr;
    logic [cnn_sched_pkg::DATA_W-1:0] mem_wdata;
    logic [cnn_sched_pkg::DATA_W-1:0] mem_rdata;

    layer_config u_layer_config (
        .clk        (clk),
        .arst_n     (arst_n),
        .cfg_val    (cfg_val),
        .cfg        (cfg),
        .layer_done (layer_done),
        .cfg_valid  (cfg_valid),
        .cfg_full   (cfg_full),
        .head       (head)
    );

    loop_sequencer u_loop_sequencer (
        .clk        (clk),
        .arst_n     (arst_n),
        .cfg_valid  (cfg_valid),
        .head       (head),
        .act_done   (act_done),
        .wgt_done   (wgt_done),
        .act_start  (act_start),
        .act_cmd    (act_cmd),
        .wgt_start  (wgt_start),
        .wgt_cmd    (wgt_cmd),
        .layer_done (layer_done),
        .busy       (busy)
    );

    // Both fetchers share the buffer read data
    tile_fetch act_fetch (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (act_start),
        .cmd       (act_cmd),
        .req       (act_req),
        .raddr     (act_addr),
        .gnt       (act_gnt),
        .rvalid    (act_rvalid),
        .rdata     (mem_rdata),
        .word_val  (act_val),
        .word_data (act_data),
        .tile_done (act_done)
    );

    tile_fetch wgt_fetch (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (wgt_start),
        .cmd       (wgt_cmd),
        .req       (wgt_req),
        .raddr     (wgt_addr),
        .gnt       (wgt_gnt),
        .rvalid    (wgt_rvalid),
        .rdata     (mem_rdata),
        .word_val  (wgt_val),
        .word_data (wgt_data),
        .tile_done (wgt_done)
    );

    buf_arbiter u_buf_arbiter (
        .clk        (clk),
        .arst_n     (arst_n),
        .host_wr_en (mem_wr_en),
        .host_wr    (mem_wr),
        .act_req    (act_req),
        .act_addr   (act_addr),
        .wgt_req    (wgt_req),
        .wgt_addr   (wgt_addr),
        .act_gnt    (act_gnt),
        .wgt_gnt    (wgt_gnt),
        .act_rvalid (act_rvalid),
        .wgt_rvalid (wgt_rvalid),
        .mem_en     (mem_en),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    tile_buffer u_tile_buffer (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

// File: hw/layer_config.sv
`timescale 1ns/1ps
// Layer configuration queue
// Holds the layer entries pushed by the host and presents the oldest
// one as the current layer. That entry leaves the queue only when the
// sequencer reports the layer complete.
module layer_config (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      cfg_val,
    input  cnn_sched_pkg::layer_cfg_t cfg,
    input  logic                      layer_done,
    output logic                      cfg_valid,
    output logic                      cfg_full,
    output cnn_sched_pkg::layer_cfg_t head
);

    // ============================================================
    // Storage and pointers
    // ============================================================
    cnn_sched_pkg::layer_cfg_t           entries [cnn_sched_pkg::CFG_DEPTH];
    logic [cnn_sched_pkg::CFG_PTR_W-1:0] wr_ptr;
    logic [cnn_sched_pkg::CFG_PTR_W-1:0] rd_ptr;
    logic [cnn_sched_pkg::CFG_PTR_W:0]   count;
    logic                                push;
    logic                                pop;

    // Push into a full queue is lost
    assign push = cfg_val && !cfg_full;
    // Only pop a real entry
    assign pop  = layer_done && cfg_valid;

    assign cfg_valid = (count != '0);
    assign cfg_full  = (count == cnn_sched_pkg::CFG_DEPTH);

    // Head shown straight from storage
    assign head = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= cfg;
        end
    end

    // ============================================================
    // Pointer and occupancy update
    // ============================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap naturally at CFG_DEPTH
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hw/loop_sequencer.sv
`timescale 1ns/1ps
// Layer loop sequencer
// Walks patches (outer) and filter groups (inner) of the head layer.
// Each step starts the activation and weight fetchers, waits for both
// tiles, then advances. The last step pulses layer_done to pop the queue.
module loop_sequencer (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      cfg_valid,
    input  cnn_sched_pkg::layer_cfg_t head,
    input  logic                      act_done,
    input  logic                      wgt_done,
    output logic                      act_start,
    output cnn_sched_pkg::fetch_cmd_t act_cmd,
    output logic                      wgt_start,
    output cnn_sched_pkg::fetch_cmd_t wgt_cmd,
    output logic                      layer_done,
    output logic                      busy
);

    cnn_sched_pkg::seq_state_e        state;
    cnn_sched_pkg::seq_state_e        state_nxt;
    logic [3:0]                       pat_cnt;
    logic [2:0]                       grp_cnt;
    logic [cnn_sched_pkg::ADDR_W-1:0] act_ofs;
    logic [cnn_sched_pkg::ADDR_W-1:0] wgt_ofs;
    logic [cnn_sched_pkg::ADDR_W-1:0] tile_len;
    logic                             act_seen;
    logic                             wgt_seen;
    logic                             both_done;
    logic                             grp_last;
    logic                             last_step;

    // Real tile length is stored value plus one
    assign tile_len  = {4'd0, head.len_row} + 8'd1;
    // Done pulses may land in different cycles
    assign both_done = (act_seen || act_done) && (wgt_seen || wgt_done);
    assign grp_last  = (grp_cnt == head.num_ftr_grp);
    assign last_step = grp_last && (pat_cnt == head.num_pat);

    // ============================================================
    // FSM
    // ============================================================
    always_comb begin
        state_nxt = state;
        case (state)
            cnn_sched_pkg::SEQ_IDLE: begin
                if (cfg_valid) state_nxt = cnn_sched_pkg::SEQ_ISSUE;
            end
            // Falls back to idle if the queue ran dry
            cnn_sched_pkg::SEQ_ISSUE: begin
                state_nxt = cfg_valid ? cnn_sched_pkg::SEQ_WAIT : cnn_sched_pkg::SEQ_IDLE;
            end
            cnn_sched_pkg::SEQ_WAIT: begin
                if (both_done) state_nxt = cnn_sched_pkg::SEQ_STEP;
            end
            // Also goes straight on to the next layer, if any
            default: state_nxt = cnn_sched_pkg::SEQ_ISSUE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= cnn_sched_pkg::SEQ_IDLE;
            pat_cnt  <= '0;
            grp_cnt  <= '0;
            act_ofs  <= '0;
            wgt_ofs  <= '0;
            act_seen <= 1'b0;
            wgt_seen <= 1'b0;
        end else begin
            state <= state_nxt;
            // Remember early done pulses until both are in
            if (state == cnn_sched_pkg::SEQ_WAIT && !both_done) begin
                act_seen <= act_seen || act_done;
                wgt_seen <= wgt_seen || wgt_done;
            end else begin
                act_seen <= 1'b0;
                wgt_seen <= 1'b0;
            end
            // Loop advance
            if (state == cnn_sched_pkg::SEQ_STEP) begin
                if (last_step) begin
                    pat_cnt <= '0;
                    grp_cnt <= '0;
                    act_ofs <= '0;
                    wgt_ofs <= '0;
                end else if (grp_last) begin
                    pat_cnt <= pat_cnt + 1'b1;
                    grp_cnt <= '0;
                    act_ofs <= act_ofs + tile_len;
                    wgt_ofs <= '0;
                end else begin
                    grp_cnt <= grp_cnt + 1'b1;
                    wgt_ofs <= wgt_ofs + tile_len;
                end
            end
        end
    end

    // ============================================================
    // Outputs
    // ============================================================
    assign act_start    = (state == cnn_sched_pkg::SEQ_ISSUE) && cfg_valid;
    assign wgt_start    = act_start;
    // Addresses wrap modulo 256
    assign act_cmd.base = head.act_base + act_ofs;
    assign act_cmd.len  = head.len_row;
    assign wgt_cmd.base = head.wgt_base + wgt_ofs;
    assign wgt_cmd.len  = head.len_row;
    assign layer_done   = (state == cnn_sched_pkg::SEQ_STEP) && last_step;
    // Head entry stays queued for the whole layer
    assign busy         = cfg_valid && (state != cnn_sched_pkg::SEQ_IDLE);

endmodule

// File: hw/tile_buffer.sv
`timescale 1ns/1ps
// Tile buffer
// Single-port synchronous memory, 256 words, loaded by the host.
// Read data appears one cycle after the read is enabled.
module tile_buffer (
    input  logic                             clk,
    input  logic                             en,
    input  logic                             we,
    input  logic [cnn_sched_pkg::ADDR_W-1:0] addr,
    input  logic [cnn_sched_pkg::DATA_W-1:0] wdata,
    output logic [cnn_sched_pkg::DATA_W-1:0] rdata
);

    logic [cnn_sched_pkg::DATA_W-1:0] mem [1 << cnn_sched_pkg::ADDR_W];

    // Write or registered read, never both
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// File: hw/tile_fetch.sv
`timescale 1ns/1ps
// Tile fetcher
// Reads one contiguous tile from the shared buffer through the arbiter
// and streams the returned words out in address order. Issued and
// returned words are counted apart, so requests run ahead of data.
module tile_fetch (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             start,
    input  cnn_sched_pkg::fetch_cmd_t        cmd,
    output logic                             req,
    output logic [cnn_sched_pkg::ADDR_W-1:0] raddr,
    input  logic                             gnt,
    input  logic                             rvalid,
    input  logic [cnn_sched_pkg::DATA_W-1:0] rdata,
    output logic                             word_val,
    output logic [cnn_sched_pkg::DATA_W-1:0] word_data,
    output logic                             tile_done
);

    logic [3:0] len_q;
    logic [3:0] issue_cnt;
    logic [3:0] ret_cnt;

    // Tile address and length, loaded per start
    always_ff @(posedge clk) begin
        if (start) begin
            raddr <= cmd.base;
            len_q <= cmd.len;
        end else if (gnt) begin
            raddr <= raddr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req       <= 1'b0;
            issue_cnt <= '0;
            ret_cnt   <= '0;
        end else if (start) begin
            req       <= 1'b1;
            issue_cnt <= '0;
            ret_cnt   <= '0;
        end else begin
            // Drop req once the last word is granted
            if (gnt) begin
                issue_cnt <= issue_cnt + 1'b1;
                if (issue_cnt == len_q) req <= 1'b0;
            end
            if (rvalid) begin
                ret_cnt <= ret_cnt + 1'b1;
            end
        end
    end

    // Returned word goes out the cycle it arrives
    assign word_val  = rvalid;
    assign word_data = rdata;
    assign tile_done = rvalid && (ret_cnt == len_q);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the layer scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module cnn_sched_tb \
    -f cnn_sched.f -o cnn_sched_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cnn_sched_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    exit 1
fi
exit 0

// File: tb/cnn_sched_tb.sv
`timescale 1ns/1ps
// Layer scheduler testbench
// Fills the tile buffer with LFSR data, pushes layer entries and checks
// both tile streams, the layer_done pulses and the queue full flag
// against a model built from the loop nest and address rules.
module cnn_sched_tb;

    logic                             clk;
    logic                             arst_n;
    logic                             cfg_val;
    cnn_sched_pkg::layer_cfg_t        cfg;
    logic                             cfg_full;
    logic                             mem_wr_en;
    cnn_sched_pkg::mem_wr_t           mem_wr;
    logic                             act_val;
    logic [cnn_sched_pkg::DATA_W-1:0] act_data;
    logic                             wgt_val;
    logic [cnn_sched_pkg::DATA_W-1:0] wgt_data;
    logic                             layer_done;
    logic                             busy;

    // Shadow of the buffer contents and the collected streams
    logic [cnn_sched_pkg::DATA_W-1:0] shadow [256];
    logic [cnn_sched_pkg::DATA_W-1:0] act_q [$];
    logic [cnn_sched_pkg::DATA_W-1:0] wgt_q [$];
    logic [cnn_sched_pkg::DATA_W-1:0] exp_act [$];
    logic [cnn_sched_pkg::DATA_W-1:0] exp_wgt [$];
    logic [15:0]                      lfsr;
    int done_cnt;
    int act_mark;
    int wgt_mark;
    int done_mark;
    int exp_layers;
    int errors;
    int err_mark;
    int tests_run;
    int tests_bad;

    cnn_sched_top UUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .cfg_val    (cfg_val),
        .cfg        (cfg),
        .cfg_full   (cfg_full),
        .mem_wr_en  (mem_wr_en),
        .mem_wr     (mem_wr),
        .act_val    (act_val),
        .act_data   (act_data),
        .wgt_val    (wgt_val),
        .wgt_data   (wgt_data),
        .layer_done (layer_done),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Output monitors, sampled on the rising edge
    initial done_cnt = 0;
    always @(posedge clk) begin
        if (act_val) act_q.push_back(act_data);
        if (wgt_val) wgt_q.push_back(wgt_data);
        if (layer_done) done_cnt = done_cnt + 1;
    end

    // ============================================================
    // Stimulus helpers
    // ============================================================
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit of the word
    function automatic logic [15:0] random_word();
        logic [15:0] w;
        w = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr = lfsr_step(lfsr);
            w    = {w[14:0], lfsr[0]};
        end
        return w;
    endfunction

    function automatic cnn_sched_pkg::layer_cfg_t make_cfg(
        input logic [3:0] pat,
        input logic [2:0] grp,
        input logic [3:0] len,
        input logic [7:0] act,
        input logic [7:0] wgt
    );
        cnn_sched_pkg::layer_cfg_t c;
        c.num_pat     = pat;
        c.num_ftr_grp = grp;
        c.len_row     = len;
        c.act_base    = act;
        c.wgt_base    = wgt;
        return c;
    endfunction

    // Whole buffer, address mixed into the data
    task automatic load_buffer();
        logic [15:0] word;
        for (int a = 0; a < 256; a++) begin
            word = random_word() ^ {a[7:0], ~a[7:0]};
            @(negedge clk);
            mem_wr_en   = 1'b1;
            mem_wr.addr = a[7:0];
            mem_wr.data = word;
            shadow[a]   = word;
        end
        @(negedge clk);
        mem_wr_en = 1'b0;
    endtask

    // Patch outer, group inner, tile base advances by the tile length
    task automatic add_expected(input cnn_sched_pkg::layer_cfg_t c);
        int tile;
        int a;
        int w;
        tile = int'(c.len_row) + 1;
        for (int p = 0; p <= int'(c.num_pat); p++) begin
            for (int g = 0; g <= int'(c.num_ftr_grp); g++) begin
                for (int i = 0; i < tile; i++) begin
                    a = (int'(c.act_base) + p * tile + i) % 256;
                    w = (int'(c.wgt_base) + g * tile + i) % 256;
                    exp_act.push_back(shadow[a]);
                    exp_wgt.push_back(shadow[w]);
                end
            end
        end
    endtask

    // ============================================================
    // Compare tasks
    // ============================================================
    task automatic check_word(input logic [cnn_sched_pkg::DATA_W-1:0] got,
                              input logic [cnn_sched_pkg::DATA_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_cfg_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // Back-to-back pushes, queue occupancy modeled from its depth
    task automatic push_layers(input cnn_sched_pkg::layer_cfg_t list [$], input int occupied);
        int held;
        held = occupied;
        for (int k = 0; k < list.size(); k++) begin
            @(negedge clk);
            if (k > 0) begin
                check_cfg_flag(cfg_full, logic'(held >= cnn_sched_pkg::CFG_DEPTH),
                               $sformatf("cfg_full after push %0d", k - 1));
            end
            cfg_val = 1'b1;
            cfg     = list[k];
            // Pushes into a full queue vanish
            if (held < cnn_sched_pkg::CFG_DEPTH) begin
                held++;
                exp_layers++;
                add_expected(list[k]);
            end
        end
        @(negedge clk);
        cfg_val = 1'b0;
        check_cfg_flag(cfg_full, logic'(held >= cnn_sched_pkg::CFG_DEPTH),
                       "cfg_full after last push");
    endtask

    // ============================================================
    // Waits
    // ============================================================
    task automatic wait_busy(input int limit);
        int cycles;
        cycles = 0;
        while (!busy && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!busy) begin
            $display("Timeout: busy never went high within %0d cycles", limit);
            errors++;
        end
    endtask

    task automatic wait_idle(input int limit);
        int cycles;
        cycles = 0;
        while (((done_cnt - done_mark) < exp_layers || busy) && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if ((done_cnt - done_mark) < exp_layers || busy) begin
            $display("Timeout: layers still running after %0d cycles", limit);
            errors++;
        end
    endtask

    // ============================================================
    // Test bookkeeping
    // ============================================================
    task automatic start_test();
        exp_act.delete();
        exp_wgt.delete();
        act_mark   = act_q.size();
        wgt_mark   = wgt_q.size();
        done_mark  = done_cnt;
        exp_layers = 0;
        err_mark   = errors;
    endtask

    task automatic finish_test(input string name);
        int n_act;
        int n_wgt;
        n_act = act_q.size() - act_mark;
        n_wgt = wgt_q.size() - wgt_mark;
        check_count(done_cnt - done_mark, exp_layers, "layer_done pulses");
        check_count(n_act, exp_act.size(), "act word count");
        check_count(n_wgt, exp_wgt.size(), "wgt word count");
        for (int i = 0; i < n_act && i < exp_act.size(); i++) begin
            check_word(act_q[act_mark + i], exp_act[i], $sformatf("act word %0d", i));
        end
        for (int i = 0; i < n_wgt && i < exp_wgt.size(); i++) begin
            check_word(wgt_q[wgt_mark + i], exp_wgt[i], $sformatf("wgt word %0d", i));
        end
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s: pass", name);
        end else begin
            tests_bad++;
            $display("test %s: FAIL with %0d errors", name, errors - err_mark);
        end
    endtask

    // ============================================================
    // Tests
    // ============================================================
    task automatic test_reset();
        start_test();
        @(negedge clk);
        check_cfg_flag(busy, 1'b0, "busy after reset");
        check_cfg_flag(act_val, 1'b0, "act_val after reset");
        check_cfg_flag(wgt_val, 1'b0, "wgt_val after reset");
        check_cfg_flag(layer_done, 1'b0, "layer_done after reset");
        check_cfg_flag(cfg_full, 1'b0, "cfg_full after reset");
        finish_test("reset");
    endtask

    task automatic test_single_step();
        cnn_sched_pkg::layer_cfg_t list [$];
        start_test();
        list.push_back(make_cfg(4'd0, 3'd0, 4'd3, 8'h10, 8'h80));
        push_layers(list, 0);
        wait_idle(500);
        finish_test("single_step");
    endtask

    // Patch tiles at F8, FB, FE so the last one wraps
    task automatic test_loop_nest();
        cnn_sched_pkg::layer_cfg_t list [$];
        start_test();
        list.push_back(make_cfg(4'd2, 3'd1, 4'd2, 8'hF8, 8'h40));
        push_layers(list, 0);
        wait_idle(1000);
        finish_test("loop_nest");
    endtask

    task automatic test_queued_layers();
        cnn_sched_pkg::layer_cfg_t list [$];
        start_test();
        list.push_back(make_cfg(4'd1, 3'd0, 4'd1, 8'h30, 8'h60));
        list.push_back(make_cfg(4'd0, 3'd2, 4'd0, 8'h50, 8'hA0));
        list.push_back(make_cfg(4'd1, 3'd1, 4'd3, 8'hC0, 8'h10));
        push_layers(list, 0);
        wait_idle(2000);
        finish_test("queued_layers");
    endtask

    // Long first layer keeps the head entry queued during the burst
    task automatic test_queue_full();
        cnn_sched_pkg::layer_cfg_t first [$];
        cnn_sched_pkg::layer_cfg_t burst [$];
        start_test();
        first.push_back(make_cfg(4'd3, 3'd3, 4'd7, 8'h00, 8'h80));
        for (int k = 0; k < 5; k++) begin
            burst.push_back(make_cfg(4'd0, 3'(k % 2), 4'(k + 1),
                                     8'(8'h20 + 16 * k), 8'(8'h90 + 16 * k)));
        end
        push_layers(first, 0);
        wait_busy(50);
        push_layers(burst, 1);
        wait_idle(6000);
        finish_test("queue_full");
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        lfsr      = 16'd10;
        errors    = 0;
        err_mark  = 0;
        tests_run = 0;
        tests_bad = 0;
        arst_n    = 1'b0;
        cfg_val   = 1'b0;
        cfg       = '0;
        mem_wr_en = 1'b0;
        mem_wr    = '0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        test_reset();
        load_buffer();
        test_single_step();
        test_loop_nest();
        test_queued_layers();
        test_queue_full();
        $display("tests run %0d, failing %0d, errors %0d", tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
